//--- design/l2_pkg.sv
package l2_pkg;

  // ---------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------
  localparam int ELEM_W = 11;  // element and arithmetic word.
  localparam int LEAF_W = 6;

  // ---------------------------------------------------------------------
  // pipeline shape
  // ---------------------------------------------------------------------
  // three adder levels reduce at most eight squares.
  localparam int TREE_LEVELS = 3;

  // diff stage, square stage, then the tree levels.
  localparam int PIPE_DEPTH = 2 + TREE_LEVELS;

  // ---------------------------------------------------------------------
  // types
  // ---------------------------------------------------------------------
  typedef logic signed [ELEM_W-1:0] elem_t;  // element or difference.
  typedef logic        [ELEM_W-1:0] sq_t;    // square, low bits only.
  typedef logic        [ELEM_W-1:0] dist_t;  // partial or final sum.
  typedef logic        [LEAF_W-1:0] leaf_idx_t;

endpackage

//--- design/l2_diff_stage.sv
`timescale 1ns/1ps

module l2_diff_stage
  import l2_pkg::*;
#(
  parameter int NUM_CAND  = 8,
  parameter int PATCH_LEN = 5
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      query_valid,
  input  leaf_idx_t leaf_idx,
  input  elem_t     query_patch    [PATCH_LEN],
  input  elem_t     candidate_leaf [NUM_CAND][PATCH_LEN],
  output logic      diff_valid,
  output leaf_idx_t diff_leaf_idx,
  output elem_t     patch_diff     [NUM_CAND][PATCH_LEN]
);

  // ---------------------------------------------------------------------
  // valid and leaf index delay lines, first step
  // ---------------------------------------------------------------------
  // both shift on every edge, query or not.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      diff_valid    <= 1'b0;
      diff_leaf_idx <= '0;
    end else begin
      diff_valid    <= query_valid;
      diff_leaf_idx <= leaf_idx;
    end
  end

  // ---------------------------------------------------------------------
  // query minus candidate
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_CAND; c++) begin
        for (int p = 0; p < PATCH_LEN; p++) begin
          patch_diff[c][p] <= '0;
        end
      end
    end else if (query_valid) begin
      for (int c = 0; c < NUM_CAND; c++) begin
        for (int p = 0; p < PATCH_LEN; p++) begin
          // wraps to ELEM_W bits.
          patch_diff[c][p] <= query_patch[p] - candidate_leaf[c][p];
        end
      end
    end
  end

endmodule

//--- design/l2_square_stage.sv
`timescale 1ns/1ps

module l2_square_stage
  import l2_pkg::*;
#(
  parameter int NUM_CAND  = 8,
  parameter int PATCH_LEN = 5
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      diff_valid,
  input  leaf_idx_t diff_leaf_idx,
  input  elem_t     patch_diff [NUM_CAND][PATCH_LEN],
  output logic      sq_valid,
  output leaf_idx_t sq_leaf_idx,
  output sq_t       diff_sq    [NUM_CAND][PATCH_LEN]
);

  sq_t sq_next [NUM_CAND][PATCH_LEN];

  // low ELEM_W bits of the product match for signed and unsigned.
  always_comb begin
    for (int c = 0; c < NUM_CAND; c++) begin
      for (int p = 0; p < PATCH_LEN; p++) begin
        sq_next[c][p] = sq_t'(patch_diff[c][p] * patch_diff[c][p]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sq_valid    <= 1'b0;
      sq_leaf_idx <= '0;
    end else begin
      sq_valid    <= diff_valid;
      sq_leaf_idx <= diff_leaf_idx;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_CAND; c++) begin
        for (int p = 0; p < PATCH_LEN; p++) begin
          diff_sq[c][p] <= '0;
        end
      end
    end else if (diff_valid) begin
      diff_sq <= sq_next;  // hold otherwise.
    end
  end

endmodule

//--- design/l2_add_tree.sv
`timescale 1ns/1ps

module l2_add_tree
  import l2_pkg::*;
#(
  parameter int NUM_CAND  = 8,
  parameter int PATCH_LEN = 5
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      sq_valid,
  input  leaf_idx_t sq_leaf_idx,
  input  sq_t       diff_sq [NUM_CAND][PATCH_LEN],
  output logic      dist_valid,
  output leaf_idx_t dist_leaf_idx,
  output dist_t     l2_dist [NUM_CAND]
);

  localparam int LEAVES = 1 << TREE_LEVELS;  // 8 inputs per candidate.

  dist_t     padded [NUM_CAND][LEAVES];
  dist_t     lvl1   [NUM_CAND][LEAVES/2];
  dist_t     lvl2   [NUM_CAND][LEAVES/4];
  logic      lvl1_valid;
  logic      lvl2_valid;
  leaf_idx_t lvl1_leaf_idx;
  leaf_idx_t lvl2_leaf_idx;

  // unused leaves read as zero.
  always_comb begin
    for (int c = 0; c < NUM_CAND; c++) begin
      for (int p = 0; p < LEAVES; p++) begin
        padded[c][p] = '0;
      end
      for (int p = 0; p < PATCH_LEN; p++) begin
        padded[c][p] = diff_sq[c][p];
      end
    end
  end

  // ---------------------------------------------------------------------
  // last three steps of the valid and leaf index lines
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lvl1_valid    <= 1'b0;
      lvl2_valid    <= 1'b0;
      dist_valid    <= 1'b0;
      lvl1_leaf_idx <= '0;
      lvl2_leaf_idx <= '0;
      dist_leaf_idx <= '0;
    end else begin
      lvl1_valid    <= sq_valid;
      lvl2_valid    <= lvl1_valid;
      dist_valid    <= lvl2_valid;
      lvl1_leaf_idx <= sq_leaf_idx;
      lvl2_leaf_idx <= lvl1_leaf_idx;
      dist_leaf_idx <= lvl2_leaf_idx;
    end
  end

  // ---------------------------------------------------------------------
  // adder levels, each gated by its own valid step
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_CAND; c++) begin
        for (int i = 0; i < LEAVES/2; i++) begin
          lvl1[c][i] <= '0;
        end
        for (int i = 0; i < LEAVES/4; i++) begin
          lvl2[c][i] <= '0;
        end
        l2_dist[c] <= '0;
      end
    end else begin
      if (sq_valid) begin
        for (int c = 0; c < NUM_CAND; c++) begin
          for (int i = 0; i < LEAVES/2; i++) begin
            lvl1[c][i] <= padded[c][2*i] + padded[c][2*i+1];  // pair sums.
          end
        end
      end
      if (lvl1_valid) begin
        for (int c = 0; c < NUM_CAND; c++) begin
          for (int i = 0; i < LEAVES/4; i++) begin
            lvl2[c][i] <= lvl1[c][2*i] + lvl1[c][2*i+1];
          end
        end
      end
      if (lvl2_valid) begin
        for (int c = 0; c < NUM_CAND; c++) begin
          l2_dist[c] <= lvl2[c][0] + lvl2[c][1];  // wraps to ELEM_W.
        end
      end
    end
  end

endmodule

//--- design/l2_kernel.sv
`timescale 1ns/1ps

module l2_kernel
  import l2_pkg::*;
#(
  parameter int NUM_CAND  = 8,
  parameter int PATCH_LEN = 5  // 2 to 8.
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      query_valid,
  input  leaf_idx_t leaf_idx,
  input  elem_t     query_patch    [PATCH_LEN],
  input  elem_t     candidate_leaf [NUM_CAND][PATCH_LEN],
  output logic      dist_valid,
  output leaf_idx_t dist_leaf_idx,
  output dist_t     l2_dist        [NUM_CAND]
);

  logic      diff_valid;
  leaf_idx_t diff_leaf_idx;
  elem_t     patch_diff [NUM_CAND][PATCH_LEN];

  logic      sq_valid;
  leaf_idx_t sq_leaf_idx;
  sq_t       diff_sq    [NUM_CAND][PATCH_LEN];

  // ---------------------------------------------------------------------
  // diff, square, three tree levels. five edges in all.
  // ---------------------------------------------------------------------
  l2_diff_stage #(
    .NUM_CAND  (NUM_CAND),
    .PATCH_LEN (PATCH_LEN)
  ) u_diff (
    .clk            (clk),
    .rst_n          (rst_n),
    .query_valid    (query_valid),
    .leaf_idx       (leaf_idx),
    .query_patch    (query_patch),
    .candidate_leaf (candidate_leaf),
    .diff_valid     (diff_valid),
    .diff_leaf_idx  (diff_leaf_idx),
    .patch_diff     (patch_diff)
  );

  l2_square_stage #(
    .NUM_CAND  (NUM_CAND),
    .PATCH_LEN (PATCH_LEN)
  ) u_square (
    .clk           (clk),
    .rst_n         (rst_n),
    .diff_valid    (diff_valid),
    .diff_leaf_idx (diff_leaf_idx),
    .patch_diff    (patch_diff),
    .sq_valid      (sq_valid),
    .sq_leaf_idx   (sq_leaf_idx),
    .diff_sq       (diff_sq)
  );

  l2_add_tree #(
    .NUM_CAND  (NUM_CAND),
    .PATCH_LEN (PATCH_LEN)
  ) u_tree (
    .clk           (clk),
    .rst_n         (rst_n),
    .sq_valid      (sq_valid),
    .sq_leaf_idx   (sq_leaf_idx),
    .diff_sq       (diff_sq),
    .dist_valid    (dist_valid),
    .dist_leaf_idx (dist_leaf_idx),
    .l2_dist       (l2_dist)
  );

endmodule

//--- tests/l2_kernel_checker.sv
`timescale 1ns/1ps

module l2_kernel_checker
  import l2_pkg::*;
#(
  parameter int NUM_CAND = 8
) (
  input logic      clk,
  input logic      rst_n,
  input logic      query_valid,
  input leaf_idx_t leaf_idx,
  input logic      dist_valid,
  input leaf_idx_t dist_leaf_idx,
  input dist_t     l2_dist [NUM_CAND]
);

  logic [NUM_CAND*ELEM_W-1:0] dist_flat;
  int                         live_edges;  // edges since reset release.

  always_comb begin
    for (int c = 0; c < NUM_CAND; c++) begin
      dist_flat[c*ELEM_W +: ELEM_W] = l2_dist[c];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live_edges <= 0;
    end else if (live_edges < PIPE_DEPTH) begin
      live_edges <= live_edges + 1;
    end
  end

  // ---------------------------------------------------------------------
  // output timing
  // ---------------------------------------------------------------------
  a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
    (live_edges >= PIPE_DEPTH) |-> (dist_valid == $past(query_valid, PIPE_DEPTH)))
    else $error("dist_valid is not query_valid delayed by %0d edges", PIPE_DEPTH);

  a_leaf_delay: assert property (@(posedge clk) disable iff (!rst_n)
    (live_edges >= PIPE_DEPTH) |-> (dist_leaf_idx == $past(leaf_idx, PIPE_DEPTH)))
    else $error("dist_leaf_idx is not leaf_idx delayed by %0d edges", PIPE_DEPTH);

  a_dist_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (live_edges >= 1 && !dist_valid) |-> $stable(dist_flat))
    else $error("l2_dist changed without dist_valid");

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !dist_valid)
    else $error("dist_valid high during reset");

endmodule

bind l2_kernel l2_kernel_checker #(.NUM_CAND(NUM_CAND)) u_checker (
  .clk           (clk),
  .rst_n         (rst_n),
  .query_valid   (query_valid),
  .leaf_idx      (leaf_idx),
  .dist_valid    (dist_valid),
  .dist_leaf_idx (dist_leaf_idx),
  .l2_dist       (l2_dist)
);

//--- tests/l2_kernel_tb.sv
`timescale 1ns/1ps

module l2_kernel_tb
  import l2_pkg::*;
();

  localparam int NUM_CAND  = 8;
  localparam int PATCH_LEN = 5;
  localparam int TIMEOUT   = 4 * PIPE_DEPTH;  // cycles per wait.

  typedef logic [NUM_CAND*ELEM_W-1:0] dist_vec_t;

  logic      clk;
  logic      rst_n;
  logic      query_valid;
  leaf_idx_t leaf_idx;
  elem_t     query_patch    [PATCH_LEN];
  elem_t     candidate_leaf [NUM_CAND][PATCH_LEN];
  logic      dist_valid;
  leaf_idx_t dist_leaf_idx;
  dist_t     l2_dist        [NUM_CAND];

  logic [31:0]           lfsr_state = 32'h2a63;
  dist_vec_t             exp_dist_q [$];
  leaf_idx_t             exp_leaf_q [$];
  logic [PIPE_DEPTH-1:0] valid_hist;
  leaf_idx_t             leaf_hist [PIPE_DEPTH];
  dist_t                 last_dist [NUM_CAND];

  l2_kernel u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .query_valid    (query_valid),
    .leaf_idx       (leaf_idx),
    .query_patch    (query_patch),
    .candidate_leaf (candidate_leaf),
    .dist_valid     (dist_valid),
    .dist_leaf_idx  (dist_leaf_idx),
    .l2_dist        (l2_dist)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // taps 32, 22, 2, 1. one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // squares and their sum wrap mod 2^11.
  function automatic dist_vec_t expected_dists();
    dist_vec_t v;
    int        d;
    longint    sq;
    int        sum;
    for (int c = 0; c < NUM_CAND; c++) begin
      sum = 0;
      for (int p = 0; p < PATCH_LEN; p++) begin
        d = int'(query_patch[p]) - int'(candidate_leaf[c][p]);
        sq = longint'(d) * longint'(d);
        sum = sum + int'(sq % 2048);
      end
      v[c*ELEM_W +: ELEM_W] = dist_t'(sum % 2048);
    end
    return v;
  endfunction

  // ---------------------------------------------------------------------
  // compare tasks
  // ---------------------------------------------------------------------
  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_dist(input string name, input dist_t act, input dist_t exp);
    if (act !== exp) begin
      $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_leaf(input string name, input leaf_idx_t act, input leaf_idx_t exp);
    if (act !== exp) begin
      $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_valid(input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERR %0t dist_valid expected %0b got %0b", $time, exp, act);
      abort_run();
    end
  endtask

  task automatic expect_all_zero();
    check_valid(dist_valid, 1'b0);
    check_leaf("dist_leaf_idx", dist_leaf_idx, '0);
    for (int c = 0; c < NUM_CAND; c++) begin
      check_dist($sformatf("l2_dist[%0d]", c), l2_dist[c], '0);
    end
  endtask

  // ---------------------------------------------------------------------
  // cycle monitor for valid, leaf index and the idle hold
  // ---------------------------------------------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_hist <= '0;
      for (int i = 0; i < PIPE_DEPTH; i++) leaf_hist[i] <= '0;
    end else begin
      valid_hist <= {valid_hist[PIPE_DEPTH-2:0], query_valid};
      leaf_hist[0] <= leaf_idx;
      for (int i = 1; i < PIPE_DEPTH; i++) leaf_hist[i] <= leaf_hist[i-1];
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      check_valid(dist_valid, valid_hist[PIPE_DEPTH-1]);
      check_leaf("dist_leaf_idx", dist_leaf_idx, leaf_hist[PIPE_DEPTH-1]);
      for (int c = 0; c < NUM_CAND; c++) begin
        if (!dist_valid) check_dist($sformatf("l2_dist[%0d]", c), l2_dist[c], last_dist[c]);
      end
    end
    last_dist = l2_dist;
  end

  // ---------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------
  task automatic fill_candidates(input int first);
    for (int c = first; c < NUM_CAND; c++) begin
      for (int p = 0; p < PATCH_LEN; p++) candidate_leaf[c][p] = elem_t'(rand_bits(ELEM_W));
    end
  endtask

  task automatic drive_random_query();
    for (int p = 0; p < PATCH_LEN; p++) query_patch[p] = elem_t'(rand_bits(ELEM_W));
    fill_candidates(0);
    leaf_idx = leaf_idx_t'(rand_bits(LEAF_W));
    query_valid = 1'b1;
    exp_dist_q.push_back(expected_dists());
    exp_leaf_q.push_back(leaf_idx);
  endtask

  task automatic drive_idle();  // scrambled data must not load.
    for (int p = 0; p < PATCH_LEN; p++) query_patch[p] = elem_t'(rand_bits(ELEM_W));
    fill_candidates(0);
    leaf_idx = leaf_idx_t'(rand_bits(LEAF_W));
    query_valid = 1'b0;
  endtask

  task automatic compare_result();
    dist_vec_t exp;
    leaf_idx_t exp_leaf;
    if (exp_dist_q.size() == 0) begin
      $display("dist_valid pulsed at %0t with no query outstanding", $time);
      abort_run();
    end else begin
      exp = exp_dist_q.pop_front();
      exp_leaf = exp_leaf_q.pop_front();
      for (int c = 0; c < NUM_CAND; c++) begin
        check_dist($sformatf("l2_dist[%0d]", c), l2_dist[c], exp[c*ELEM_W +: ELEM_W]);
      end
      check_leaf("dist_leaf_idx", dist_leaf_idx, exp_leaf);
    end
  endtask

  task automatic wait_pulse();
    bit seen;
    seen = 1'b0;
    for (int cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
      @(negedge clk);
      seen = dist_valid;
    end
    if (!seen) begin
      $display("timeout: no dist_valid pulse within %0d cycles at %0t", TIMEOUT, $time);
      abort_run();
    end else begin
      compare_result();
    end
  endtask

  // ---------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------
  task automatic reset_values();
    repeat (8) @(negedge clk);
    expect_all_zero();
    rst_n = 1'b1;
    @(negedge clk);
    expect_all_zero();
  endtask

  task automatic known_vectors();
    dist_vec_t exp;
    @(negedge clk);
    query_patch = '{elem_t'(10), elem_t'(-3), elem_t'(7), elem_t'(0), elem_t'(100)};
    candidate_leaf[0] = query_patch;
    // diffs 1 -2 3 -1 2 give a sum of squares of 19.
    candidate_leaf[1] = '{elem_t'(9), elem_t'(-1), elem_t'(4), elem_t'(1), elem_t'(98)};
    // large diffs make the squares and the sum wrap.
    candidate_leaf[2] = '{elem_t'(-1000), elem_t'(1000), elem_t'(-900), elem_t'(700),
                          elem_t'(-800)};
    fill_candidates(3);
    leaf_idx = 6'd37;
    query_valid = 1'b1;
    exp = expected_dists();
    exp[0 +: ELEM_W] = '0;
    exp[ELEM_W +: ELEM_W] = 11'd19;
    exp_dist_q.push_back(exp);
    exp_leaf_q.push_back(leaf_idx);
    for (int k = 1; k <= PIPE_DEPTH; k++) begin
      @(negedge clk);
      if (k == 1) drive_idle();
      check_valid(dist_valid, k == PIPE_DEPTH);
    end
    compare_result();
  endtask

  task automatic back_to_back_stream();
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          @(negedge clk);
          drive_random_query();
        end
        @(negedge clk);
        drive_idle();
      end
      for (int i = 0; i < 40; i++) wait_pulse();
    join
  endtask

  task automatic gapped_stream();
    int gap;
    fork
      for (int i = 0; i < 20; i++) begin
        @(negedge clk);
        drive_random_query();
        gap = 1 + int'(rand_bits(2));
        repeat (gap) begin
          @(negedge clk);
          drive_idle();
        end
      end
      for (int i = 0; i < 20; i++) wait_pulse();
    join
  endtask

  task automatic reset_in_flight();
    repeat (3) begin
      @(negedge clk);
      drive_random_query();
    end
    @(negedge clk);
    drive_idle();
    @(negedge clk);
    rst_n = 1'b0;  // three queries still in the pipe.
    exp_dist_q.delete();
    exp_leaf_q.delete();
    repeat (2) begin
      @(negedge clk);
      expect_all_zero();
    end
    rst_n = 1'b1;
    @(negedge clk);
    repeat (PIPE_DEPTH + 2) begin
      @(negedge clk);
      check_valid(dist_valid, 1'b0);
    end
    @(negedge clk);
    drive_random_query();
    @(negedge clk);
    drive_idle();
    wait_pulse();
  endtask

  initial begin
    rst_n = 1'b0;
    query_valid = 1'b0;
    leaf_idx = '0;
    for (int p = 0; p < PATCH_LEN; p++) query_patch[p] = '0;
    for (int c = 0; c < NUM_CAND; c++) begin
      for (int p = 0; p < PATCH_LEN; p++) candidate_leaf[c][p] = '0;
    end
    reset_values();
    known_vectors();
    back_to_back_stream();
    gapped_stream();
    reset_in_flight();
    repeat (PIPE_DEPTH) @(negedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- sim.f
design/l2_pkg.sv
design/l2_diff_stage.sv
design/l2_square_stage.sv
design/l2_add_tree.sv
design/l2_kernel.sv
tests/l2_kernel_checker.sv
tests/l2_kernel_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the l2_kernel testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module l2_kernel_tb \
  -f sim.f \
  -o l2_kernel_sim

./obj_dir/l2_kernel_sim
